/* logic/rvfi_consts.svh */
`ifndef RVFI_CONSTS_SVH
`define RVFI_CONSTS_SVH

// ----------------------------------------------------------------------
// Datapath and table sizing
// ----------------------------------------------------------------------

`define RVFI_XLEN        32  // Data width of the traced core
`define RVFI_SB_ENTRIES  8   // Scoreboard entries tracked by the tracer
`define RVFI_TID_BITS    3   // Must cover RVFI_SB_ENTRIES

// ----------------------------------------------------------------------
// Trap cause encodings
// ----------------------------------------------------------------------

`define RVFI_CAUSE_ECALL_U   8   // Environment call from U-mode
`define RVFI_CAUSE_ECALL_S   9   // Environment call from S-mode
`define RVFI_CAUSE_ECALL_M   11  // Environment call from M-mode

// Set in the cause word when the trap is an interrupt
`define RVFI_CAUSE_INTR_BIT  31

`endif

/* logic/rvfi_pkg.sv */
package rvfi_pkg;

  `include "rvfi_consts.svh"

  typedef logic [`RVFI_XLEN-1:0]     xlen_t;
  typedef logic [`RVFI_TID_BITS-1:0] tid_t;
  typedef logic [31:0]               insn_t;     // Always 32 bits, RVC zero-extended
  typedef logic [4:0]                reg_addr_t;
  typedef logic [`RVFI_XLEN/8-1:0]   be_t;
  typedef logic [1:0]                priv_t;
  typedef logic [2:0]                intr_t;

  // ----------------------------------------------------------------------
  // Probes from the core
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic  valid;
    insn_t insn;
    logic  is_compressed;
  } fetch_probe_t;

  typedef struct packed {
    logic  decoded_valid;
    logic  decoded_ack;
    logic  flush_unissued;
    tid_t  tid;            // Scoreboard slot being issued
    xlen_t rs1_data;       // Forwarded operands
    xlen_t rs2_data;
  } issue_probe_t;

  typedef struct packed {
    tid_t  tid;
    xlen_t vaddr;
    be_t   be;
    logic  is_load;
    logic  is_store;
    xlen_t store_data;
  } lsu_probe_t;

  typedef struct packed {
    logic      valid;
    logic      ack;
    logic      drop;
    tid_t      tid;
    xlen_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xlen_t     result;
    logic      ex_valid;
    xlen_t     ex_cause;
    priv_t     priv;
    logic      debug_mode;
  } commit_probe_t;

  // ----------------------------------------------------------------------
  // Tracer internal and output records
  // ----------------------------------------------------------------------

  typedef struct packed {
    insn_t insn;
    xlen_t rs1_rdata;
    xlen_t rs2_rdata;
    xlen_t mem_addr;
    be_t   mem_rmask;
    be_t   mem_wmask;
    xlen_t mem_wdata;
  } sb_entry_t;

  typedef struct packed {
    logic      valid;
    tid_t      tid;
    sb_entry_t entry;
  } sb_write_t;

  typedef struct packed {
    logic      valid;
    insn_t     insn;
    logic      trap;
    intr_t     intr;
    xlen_t     cause;
    priv_t     mode;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xlen_t     rd_wdata;
    xlen_t     pc_rdata;
    xlen_t     mem_addr;
    be_t       mem_rmask;
    be_t       mem_wmask;
    xlen_t     mem_wdata;
    xlen_t     mem_rdata;
    xlen_t     rs1_rdata;
    xlen_t     rs2_rdata;
  } rvfi_instr_t;

endpackage

/* logic/rvfi_issue_capture.sv */
`timescale 1ns/1ps

module rvfi_issue_capture (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  rvfi_pkg::fetch_probe_t fetch_i,
  input  rvfi_pkg::issue_probe_t issue_i,
  output rvfi_pkg::sb_write_t    sb_wr_o
);

  logic           hold_valid_q;
  logic           hold_valid_d;
  rvfi_pkg::insn_t hold_insn_q;
  rvfi_pkg::insn_t fetch_insn;
  logic           take;
  logic           issue;
  logic           load_slot;

  // RVC words keep only their low half
  assign fetch_insn = fetch_i.is_compressed ? {16'b0, fetch_i.insn[15:0]} : fetch_i.insn;

  assign take  = issue_i.decoded_valid && issue_i.decoded_ack;  // Slot consumed
  assign issue = take && !issue_i.flush_unissued;               // Slot consumed and kept

  // Slot refills when empty or freed by the issue in this cycle
  assign load_slot = fetch_i.valid && (!hold_valid_q || take) && !flush_i;

  always_comb begin
    hold_valid_d = hold_valid_q;
    if (take) begin
      hold_valid_d = 1'b0;
    end
    if (load_slot) begin
      hold_valid_d = 1'b1;
    end
    if (flush_i) begin
      hold_valid_d = 1'b0;  // Flush beats a same-cycle fetch
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= hold_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_slot) begin
      hold_insn_q <= fetch_insn;
    end
  end

  // Memory fields start cleared, the LSU fills them later
  always_comb begin
    sb_wr_o                 = '0;
    sb_wr_o.valid           = issue;
    sb_wr_o.tid             = issue_i.tid;
    sb_wr_o.entry.insn      = hold_insn_q;
    sb_wr_o.entry.rs1_rdata = issue_i.rs1_data;
    sb_wr_o.entry.rs2_rdata = issue_i.rs2_data;
  end

endmodule

/* logic/rvfi_sb_table.sv */
`timescale 1ns/1ps

`include "rvfi_consts.svh"

module rvfi_sb_table (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  rvfi_pkg::sb_write_t  sb_wr_i,
  input  rvfi_pkg::lsu_probe_t lsu_i,
  input  rvfi_pkg::tid_t       rd_tid_i,
  output rvfi_pkg::sb_entry_t  rd_entry_o
);

  rvfi_pkg::sb_entry_t mem_q [`RVFI_SB_ENTRIES];
  rvfi_pkg::sb_entry_t mem_d [`RVFI_SB_ENTRIES];

  // ----------------------------------------------------------------------
  // Next-state of the table
  // ----------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < `RVFI_SB_ENTRIES; i++) begin
      mem_d[i] = mem_q[i];
    end

    // Issue overwrites the whole entry
    if (sb_wr_i.valid) begin
      mem_d[sb_wr_i.tid] = sb_wr_i.entry;
    end

    // LSU update lands on top of any same-cycle issue write
    if (lsu_i.is_load) begin
      mem_d[lsu_i.tid].mem_addr  = lsu_i.vaddr;
      mem_d[lsu_i.tid].mem_rmask = lsu_i.be;
    end else if (lsu_i.is_store) begin
      mem_d[lsu_i.tid].mem_addr  = lsu_i.vaddr;
      mem_d[lsu_i.tid].mem_wmask = lsu_i.be;
      mem_d[lsu_i.tid].mem_wdata = lsu_i.store_data;
    end
  end

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RVFI_SB_ENTRIES; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `RVFI_SB_ENTRIES; i++) begin
        mem_q[i] <= mem_d[i];
      end
    end
  end

  // Commit-side lookup, no extra latency
  assign rd_entry_o = mem_q[rd_tid_i];

endmodule

/* logic/rvfi_commit_pack.sv */
`timescale 1ns/1ps

`include "rvfi_consts.svh"

module rvfi_commit_pack (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rvfi_pkg::commit_probe_t commit_i,
  input  rvfi_pkg::sb_entry_t     entry_i,
  output rvfi_pkg::rvfi_instr_t   rvfi_o
);

  logic                  exception;
  logic                  is_ecall;
  logic                  retire;
  rvfi_pkg::intr_t       intr_q;
  rvfi_pkg::intr_t       intr_d;
  rvfi_pkg::rvfi_instr_t rvfi_d;

  // ----------------------------------------------------------------------
  // Retire and trap qualification
  // ----------------------------------------------------------------------

  assign exception = commit_i.valid && commit_i.ex_valid && !commit_i.drop;

  // An ecall traps but still counts as executed
  assign is_ecall = (commit_i.ex_cause == rvfi_pkg::xlen_t'(`RVFI_CAUSE_ECALL_U)) ||
                    (commit_i.ex_cause == rvfi_pkg::xlen_t'(`RVFI_CAUSE_ECALL_S)) ||
                    (commit_i.ex_cause == rvfi_pkg::xlen_t'(`RVFI_CAUSE_ECALL_M));

  assign retire = (commit_i.ack && !commit_i.ex_valid && !commit_i.drop) ||
                  (exception && is_ecall);

  // Sticky interrupt status for the record after a trap
  always_comb begin
    intr_d = intr_q;
    if (exception && commit_i.ex_cause[`RVFI_CAUSE_INTR_BIT]) begin
      intr_d = 3'b101;
    end else if (exception) begin
      intr_d = 3'b011;
    end
    if (retire) begin
      intr_d = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Record assembly
  // ----------------------------------------------------------------------

  always_comb begin
    rvfi_d           = '0;
    rvfi_d.valid     = retire;
    rvfi_d.insn      = entry_i.insn;
    rvfi_d.trap      = exception;
    rvfi_d.intr      = intr_q;                 // Status left by the previous trap
    rvfi_d.cause     = commit_i.ex_cause;
    rvfi_d.mode      = commit_i.debug_mode ? 2'b10 : commit_i.priv;
    rvfi_d.rs1_addr  = commit_i.rs1_addr;
    rvfi_d.rs2_addr  = commit_i.rs2_addr;
    rvfi_d.rd_addr   = commit_i.rd_addr;
    rvfi_d.rd_wdata  = commit_i.result;
    rvfi_d.pc_rdata  = commit_i.pc;
    rvfi_d.mem_addr  = entry_i.mem_addr;
    rvfi_d.mem_rmask = entry_i.mem_rmask;
    rvfi_d.mem_wmask = entry_i.mem_wmask;
    rvfi_d.mem_wdata = entry_i.mem_wdata;
    rvfi_d.mem_rdata = commit_i.result;       // Load data shares the writeback bus
    rvfi_d.rs1_rdata = entry_i.rs1_rdata;
    rvfi_d.rs2_rdata = entry_i.rs2_rdata;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_q <= '0;
      rvfi_o <= '0;
    end else begin
      intr_q <= intr_d;
      rvfi_o <= rvfi_d;
    end
  end

endmodule

/* logic/rvfi_tracer_top.sv */
`timescale 1ns/1ps

module rvfi_tracer_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rvfi_pkg::fetch_probe_t  fetch_i,
  input  rvfi_pkg::issue_probe_t  issue_i,
  input  rvfi_pkg::lsu_probe_t    lsu_i,
  input  rvfi_pkg::commit_probe_t commit_i,
  input  logic                    flush_i,
  output rvfi_pkg::rvfi_instr_t   rvfi_o
);

  rvfi_pkg::sb_write_t sb_wr;     // Issue-time table write
  rvfi_pkg::sb_entry_t rd_entry;  // Entry of the committing id

  rvfi_issue_capture u_issue_capture (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .fetch_i (fetch_i),
    .issue_i (issue_i),
    .sb_wr_o (sb_wr)
  );

  rvfi_sb_table u_sb_table (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sb_wr_i    (sb_wr),
    .lsu_i      (lsu_i),
    .rd_tid_i   (commit_i.tid),
    .rd_entry_o (rd_entry)
  );

  rvfi_commit_pack u_commit_pack (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .commit_i (commit_i),
    .entry_i  (rd_entry),
    .rvfi_o   (rvfi_o)
  );

endmodule

/* sim/rvfi_tracer_sva.sv */
`timescale 1ns/1ps

`include "rvfi_consts.svh"

module rvfi_tracer_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input rvfi_pkg::commit_probe_t commit_i,
  input rvfi_pkg::rvfi_instr_t   rvfi_o
);

  logic exc;
  logic ecall;
  logic qualify;
  int   fail_count = 0;  // Failed assertions so far

  assign exc     = commit_i.valid && commit_i.ex_valid && !commit_i.drop;
  assign ecall   = commit_i.ex_cause inside {32'd8, 32'd9, 32'd11};
  assign qualify = (commit_i.ack && !commit_i.ex_valid && !commit_i.drop) || (exc && ecall);

  // ----------------------------------------------------------------------
  // Reset and timing
  // ----------------------------------------------------------------------

  a_reset_zero: assert property (@(posedge clk_i) !rst_ni |-> rvfi_o == '0)
    else begin
      fail_count++;
      $error("Record not zero during reset");
    end
  a_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |=> rvfi_o == '0)
    else begin
      fail_count++;
      $error("Record not zero right after reset");
    end
  a_valid_set: assert property (@(posedge clk_i) disable iff (!rst_ni) qualify |=> rvfi_o.valid)
    else begin
      fail_count++;
      $error("Missing valid after a qualifying commit");
    end
  a_valid_clr: assert property (@(posedge clk_i) disable iff (!rst_ni) !qualify |=> !rvfi_o.valid)
    else begin
      fail_count++;
      $error("Valid without a qualifying commit");
    end

  // Trap status and sticky interrupt field
  a_trap: assert property (@(posedge clk_i) disable iff (!rst_ni) exc |=> rvfi_o.trap)
    else begin
      fail_count++;
      $error("Trap flag missing");
    end
  a_no_trap: assert property (@(posedge clk_i) disable iff (!rst_ni) !exc |=> !rvfi_o.trap)
    else begin
      fail_count++;
      $error("Unexpected trap flag");
    end
  a_intr_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exc && !ecall && commit_i.ex_cause[`RVFI_CAUSE_INTR_BIT]) |=> ##1 rvfi_o.intr == 3'd5)
    else begin
      fail_count++;
      $error("Interrupt status not 5 after an interrupt");
    end
  a_intr_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exc && !ecall && !commit_i.ex_cause[`RVFI_CAUSE_INTR_BIT]) |=> ##1 rvfi_o.intr == 3'd3)
    else begin
      fail_count++;
      $error("Interrupt status not 3 after an exception");
    end
  a_intr_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    qualify |=> ##1 rvfi_o.intr == 3'd0)
    else begin
      fail_count++;
      $error("Interrupt status not cleared by a retire");
    end

endmodule

bind rvfi_tracer_top rvfi_tracer_sva sva0 (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .commit_i (commit_i),
  .rvfi_o   (rvfi_o)
);

/* sim/rvfi_tracer_tb.sv */
`timescale 1ns/1ps

`include "rvfi_consts.svh"

module rvfi_tracer_tb;

  localparam int  NUM_TX     = 24;
  localparam time CLK_PERIOD = 40;
  localparam time RUN_LIMIT  = NUM_TX * 6 * CLK_PERIOD + 8 * CLK_PERIOD;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    flush_i;
  rvfi_pkg::fetch_probe_t  fetch;
  rvfi_pkg::issue_probe_t  issue;
  rvfi_pkg::lsu_probe_t    lsu;
  rvfi_pkg::commit_probe_t commit;
  rvfi_pkg::rvfi_instr_t   rvfi;

  rvfi_pkg::sb_entry_t ref_tab [`RVFI_SB_ENTRIES];  // Expected table contents
  rvfi_pkg::intr_t     intr_ref;                    // Expected sticky interrupt status
  integer              seed;
  int                  checks;
  int                  errors;

  rvfi_tracer_top dut0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .fetch_i  (fetch),
    .issue_i  (issue),
    .lsu_i    (lsu),
    .commit_i (commit),
    .flush_i  (flush_i),
    .rvfi_o   (rvfi)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------------------

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_record(input rvfi_pkg::rvfi_instr_t exp);
    check_field("rvfi.valid",     32'(exp.valid),     32'(rvfi.valid));
    check_field("rvfi.insn",      exp.insn,           rvfi.insn);
    check_field("rvfi.trap",      32'(exp.trap),      32'(rvfi.trap));
    check_field("rvfi.intr",      32'(exp.intr),      32'(rvfi.intr));
    check_field("rvfi.cause",     exp.cause,          rvfi.cause);
    check_field("rvfi.mode",      32'(exp.mode),      32'(rvfi.mode));
    check_field("rvfi.rs1_addr",  32'(exp.rs1_addr),  32'(rvfi.rs1_addr));
    check_field("rvfi.rs2_addr",  32'(exp.rs2_addr),  32'(rvfi.rs2_addr));
    check_field("rvfi.rd_addr",   32'(exp.rd_addr),   32'(rvfi.rd_addr));
    check_field("rvfi.rd_wdata",  exp.rd_wdata,       rvfi.rd_wdata);
    check_field("rvfi.pc_rdata",  exp.pc_rdata,       rvfi.pc_rdata);
    check_field("rvfi.mem_addr",  exp.mem_addr,       rvfi.mem_addr);
    check_field("rvfi.mem_rmask", 32'(exp.mem_rmask), 32'(rvfi.mem_rmask));
    check_field("rvfi.mem_wmask", 32'(exp.mem_wmask), 32'(rvfi.mem_wmask));
    check_field("rvfi.mem_wdata", exp.mem_wdata,      rvfi.mem_wdata);
    check_field("rvfi.mem_rdata", exp.mem_rdata,      rvfi.mem_rdata);
    check_field("rvfi.rs1_rdata", exp.rs1_rdata,      rvfi.rs1_rdata);
    check_field("rvfi.rs2_rdata", exp.rs2_rdata,      rvfi.rs2_rdata);
  endtask

  // Builds the record the tracer should show for one commit
  function automatic rvfi_pkg::rvfi_instr_t expected_record(input rvfi_pkg::commit_probe_t c,
                                                            input rvfi_pkg::sb_entry_t e,
                                                            input rvfi_pkg::intr_t intr);
    rvfi_pkg::rvfi_instr_t r;
    logic exc;
    logic ecall;
    exc   = c.valid && c.ex_valid && !c.drop;
    ecall = c.ex_cause inside {32'd8, 32'd9, 32'd11};
    r           = '0;
    r.valid     = (c.ack && !c.ex_valid && !c.drop) || (exc && ecall);
    r.trap      = exc;
    r.intr      = intr;
    r.cause     = c.ex_cause;
    r.mode      = c.debug_mode ? 2'd2 : c.priv;
    r.insn      = e.insn;
    r.rs1_addr  = c.rs1_addr;
    r.rs2_addr  = c.rs2_addr;
    r.rd_addr   = c.rd_addr;
    r.rd_wdata  = c.result;
    r.mem_rdata = c.result;
    r.pc_rdata  = c.pc;
    r.mem_addr  = e.mem_addr;
    r.mem_rmask = e.mem_rmask;
    r.mem_wmask = e.mem_wmask;
    r.mem_wdata = e.mem_wdata;
    r.rs1_rdata = e.rs1_rdata;
    r.rs2_rdata = e.rs2_rdata;
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    rvfi_pkg::rvfi_instr_t exp;
    logic [31:0] word;
    logic        flushed;
    logic        exc;
    int          kind;
    seed     = 17823;
    checks   = 0;
    errors   = 0;
    intr_ref = '0;
    rst_ni   = 1'b0;
    flush_i  = 1'b0;
    fetch    = '0;
    issue    = '0;
    lsu      = '0;
    commit   = '0;
    for (int i = 0; i < `RVFI_SB_ENTRIES; i++) ref_tab[i] = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int n = 0; n < NUM_TX; n++) begin
      // Fetch, with flush_i on some transactions so the word is lost
      @(negedge clk_i);
      word                = $random(seed);
      fetch.valid         = 1'b1;
      fetch.insn          = word;
      fetch.is_compressed = (n % 3 == 0);
      flush_i             = (n % 6 == 4);
      if (fetch.is_compressed) word = {16'b0, word[15:0]};

      // Issue, dropped by flush_unissued on some transactions
      @(negedge clk_i);
      fetch   = '0;
      flushed = flush_i || (n % 7 == 5);
      issue.decoded_valid  = !flush_i;
      issue.decoded_ack    = !flush_i;
      issue.flush_unissued = (n % 7 == 5);
      issue.tid            = rvfi_pkg::tid_t'(n);
      issue.rs1_data       = $random(seed);
      issue.rs2_data       = $random(seed);
      flush_i              = 1'b0;
      if (!flushed) begin
        ref_tab[n % 8]           = '0;
        ref_tab[n % 8].insn      = word;
        ref_tab[n % 8].rs1_rdata = issue.rs1_data;
        ref_tab[n % 8].rs2_rdata = issue.rs2_data;
      end

      // Random load or store to the same id
      @(negedge clk_i);
      issue            = '0;
      kind             = $unsigned($random(seed)) % 3;
      lsu.tid          = rvfi_pkg::tid_t'(n);
      lsu.vaddr        = $random(seed);
      lsu.be           = rvfi_pkg::be_t'($random(seed));
      lsu.store_data   = $random(seed);
      lsu.is_load      = (kind == 1);
      lsu.is_store     = (kind == 2);
      if (kind == 1) begin
        ref_tab[n % 8].mem_addr  = lsu.vaddr;
        ref_tab[n % 8].mem_rmask = lsu.be;
      end else if (kind == 2) begin
        ref_tab[n % 8].mem_addr  = lsu.vaddr;
        ref_tab[n % 8].mem_wmask = lsu.be;
        ref_tab[n % 8].mem_wdata = lsu.store_data;
      end

      // Commit with a retire, trap, ecall, interrupt or drop
      @(negedge clk_i);
      lsu               = '0;
      commit.valid      = 1'b1;
      commit.ack        = 1'b1;
      commit.tid        = rvfi_pkg::tid_t'(n);
      commit.pc         = $random(seed);
      commit.rs1_addr   = rvfi_pkg::reg_addr_t'($random(seed));
      commit.rs2_addr   = rvfi_pkg::reg_addr_t'($random(seed));
      commit.rd_addr    = rvfi_pkg::reg_addr_t'($random(seed));
      commit.result     = $random(seed);
      commit.priv       = rvfi_pkg::priv_t'($random(seed));
      commit.debug_mode = (n % 4 == 3);
      commit.drop       = (n % 5 == 4);
      commit.ex_valid   = (n % 5 != 0);
      case (n % 5)
        1:       commit.ex_cause = 32'd2;
        2:       commit.ex_cause = (n % 3 == 0) ? 32'd8 : ((n % 3 == 1) ? 32'd9 : 32'd11);
        3:       commit.ex_cause = 32'h8000_0007;
        default: commit.ex_cause = 32'd0;
      endcase
      exp = expected_record(commit, ref_tab[n % 8], intr_ref);
      exc = commit.valid && commit.ex_valid && !commit.drop;
      if (exc) intr_ref = commit.ex_cause[`RVFI_CAUSE_INTR_BIT] ? 3'd5 : 3'd3;
      if (exp.valid) intr_ref = '0;

      // Record appears one edge after the commit
      @(negedge clk_i);
      compare_record(exp);
      commit = '0;
    end

    @(negedge clk_i);
    $display("Checks run: %0d, value errors: %0d, assertion errors: %0d",
             checks, errors, dut0.sva0.fail_count);
    if (errors == 0 && dut0.sva0.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_LIMIT);
    $display("Timeout: the stimulus did not finish within %0t ns", RUN_LIMIT);
    $display("Regression failed");
    $finish;
  end

endmodule

/* list.f */
+incdir+logic
logic/rvfi_pkg.sv
logic/rvfi_issue_capture.sv
logic/rvfi_sb_table.sv
logic/rvfi_commit_pack.sv
logic/rvfi_tracer_top.sv
sim/rvfi_tracer_sva.sv
sim/rvfi_tracer_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       := rvfi_tracer_tb
FLIST     := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
